// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_iomem_soc
FILELIST  = iomem_soc.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard design/*.sv dv/*.sv)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/gpio_ctrl.sv
`timescale 1ns/1ns

module gpio_ctrl
    import iomem_soc_pkg::*;
#(
    parameter int gpio_count = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  strb_t                 wstrb,
    input  addr_t                 addr,
    input  data_t                 wdata,
    input  logic [gpio_count-1:0] gpio_in,
    output logic                  ready,
    output data_t                 rdata,
    output logic [gpio_count-1:0] gpio_out,
    output logic [gpio_count-1:0] gpio_oe
);

    logic [gpio_count-1:0] dir_q;
    logic [gpio_count-1:0] out_q;
    logic [gpio_count-1:0] in_meta;
    logic [gpio_count-1:0] in_sync;
    data_t                 rd_word;

    // ----------------------------------------
    // Registers and input synchronizer
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dir_q   <= '0;
            out_q   <= '0;
            in_meta <= '0;
            in_sync <= '0;
            ready   <= 1'b0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            ready   <= sel;
            // Input register is read only
            if (sel && |wstrb) begin
                if (addr == GPIO_DIR_ADDR) begin
                    dir_q <= wdata[gpio_count-1:0];
                end else if (addr == GPIO_OUTPUT_ADDR) begin
                    out_q <= wdata[gpio_count-1:0];
                end
            end
        end
    end

    // Read mux, upper bits stay zero
    always_comb begin
        rd_word = '0;
        case (addr)
            GPIO_DIR_ADDR:    rd_word[gpio_count-1:0] = dir_q;
            GPIO_INPUT_ADDR:  rd_word[gpio_count-1:0] = in_sync;
            GPIO_OUTPUT_ADDR: rd_word[gpio_count-1:0] = out_q;
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= rd_word;
        end
    end

    assign gpio_oe  = dir_q;
    assign gpio_out = out_q;

endmodule

// File: design/iomem_decode.sv
`timescale 1ns/1ns

module iomem_decode
    import iomem_soc_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic  iomem_valid,
    input  addr_t iomem_addr,

    // Replies from the peripherals
    input  logic  ram_ready,
    input  logic  gpio_ready,
    input  logic  led_ready,
    input  data_t ram_rdata,
    input  data_t gpio_rdata,
    input  data_t led_rdata,

    // Gated requests
    output logic  ram_sel,
    output logic  gpio_sel,
    output logic  led_sel,

    // Merged reply to the master
    output logic  iomem_ready,
    output data_t iomem_rdata
);

    // Size of the RAM window in bytes
    localparam addr_t ram_bytes = addr_t'(4 * ram_words);

    addr_t ram_offset;
    logic  ram_hit;
    logic  gpio_hit;
    logic  led_hit;
    logic  any_ready;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    // Offset compare covers both window bounds at once
    assign ram_offset = iomem_addr - RAM_BASE;
    assign ram_hit    = ram_offset < ram_bytes;

    assign gpio_hit = (iomem_addr == GPIO_DIR_ADDR)   ||
                      (iomem_addr == GPIO_INPUT_ADDR) ||
                      (iomem_addr == GPIO_OUTPUT_ADDR);

    assign led_hit = iomem_addr == LED_FB_ADDR;

    // ----------------------------------------
    // Request gating
    // ----------------------------------------

    // No new select during the ready pulse, so one request gives one ready
    assign any_ready = ram_ready | gpio_ready | led_ready;

    assign ram_sel  = iomem_valid && !any_ready && ram_hit;
    assign gpio_sel = iomem_valid && !any_ready && gpio_hit;
    assign led_sel  = iomem_valid && !any_ready && led_hit;

    // ----------------------------------------
    // Reply merge
    // ----------------------------------------

    assign iomem_ready = any_ready;

    always_comb begin
        if (ram_ready) begin
            iomem_rdata = ram_rdata;
        end else if (gpio_ready) begin
            iomem_rdata = gpio_rdata;
        end else if (led_ready) begin
            iomem_rdata = led_rdata;
        end else begin
            iomem_rdata = '0;
        end
    end

endmodule

// File: design/iomem_soc.sv
`timescale 1ns/1ns

module iomem_soc
    import iomem_soc_pkg::*;
#(
    parameter int ram_words  = 256,
    parameter int gpio_count = 8,
    parameter int scan_div   = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // iomem bus from the external master
    input  logic                  iomem_valid,
    input  strb_t                 iomem_wstrb,
    input  addr_t                 iomem_addr,
    input  data_t                 iomem_wdata,
    output logic                  iomem_ready,
    output data_t                 iomem_rdata,

    // GPIO pins, split into input, output and enable
    input  logic [gpio_count-1:0] gpio_in,
    output logic [gpio_count-1:0] gpio_out,
    output logic [gpio_count-1:0] gpio_oe,

    // LED matrix, active low
    output logic [7:0]            leds,
    output logic [LED_COLS-1:0]   lcol
);

    // Per-peripheral selects and replies
    logic  ram_sel;
    logic  gpio_sel;
    logic  led_sel;
    logic  ram_ready;
    logic  gpio_ready;
    logic  led_ready;
    data_t ram_rdata;
    data_t gpio_rdata;
    data_t led_rdata;

    iomem_decode #(
        .ram_words (ram_words)
    ) iomem_decode_inst (
        .iomem_valid (iomem_valid),
        .iomem_addr  (iomem_addr),
        .ram_ready   (ram_ready),
        .gpio_ready  (gpio_ready),
        .led_ready   (led_ready),
        .ram_rdata   (ram_rdata),
        .gpio_rdata  (gpio_rdata),
        .led_rdata   (led_rdata),
        .ram_sel     (ram_sel),
        .gpio_sel    (gpio_sel),
        .led_sel     (led_sel),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata)
    );

    scratch_ram #(
        .ram_words (ram_words)
    ) scratch_ram_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (ram_sel),
        .wstrb (iomem_wstrb),
        .addr  (iomem_addr),
        .wdata (iomem_wdata),
        .ready (ram_ready),
        .rdata (ram_rdata)
    );

    gpio_ctrl #(
        .gpio_count (gpio_count)
    ) gpio_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (gpio_sel),
        .wstrb    (iomem_wstrb),
        .addr     (iomem_addr),
        .wdata    (iomem_wdata),
        .gpio_in  (gpio_in),
        .ready    (gpio_ready),
        .rdata    (gpio_rdata),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    led_matrix_fb #(
        .scan_div (scan_div)
    ) led_matrix_fb_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (led_sel),
        .wstrb (iomem_wstrb),
        .wdata (iomem_wdata),
        .ready (led_ready),
        .rdata (led_rdata),
        .leds  (leds),
        .lcol  (lcol)
    );

endmodule

// File: design/iomem_soc_pkg.sv
package iomem_soc_pkg;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------

    // Byte address on the iomem bus
    typedef logic [31:0] addr_t;

    // One bus data word
    typedef logic [31:0] data_t;

    // Byte write strobes, all zero for a read
    typedef logic [3:0] strb_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    localparam addr_t RAM_BASE = 32'h0000_0000;

    // GPIO register block
    localparam addr_t GPIO_DIR_ADDR    = 32'h1000_0000;
    localparam addr_t GPIO_INPUT_ADDR  = 32'h1000_0004;
    localparam addr_t GPIO_OUTPUT_ADDR = 32'h1000_0008;

    // Framebuffer word of the LED matrix
    localparam addr_t LED_FB_ADDR = 32'h1000_0010;

    // One matrix column per framebuffer byte
    localparam int LED_COLS = 4;

endpackage

// File: design/led_matrix_fb.sv
`timescale 1ns/1ns

module led_matrix_fb
    import iomem_soc_pkg::*;
#(
    parameter int scan_div = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel,
    input  strb_t               wstrb,
    input  data_t               wdata,
    output logic                ready,
    output data_t               rdata,
    output logic [7:0]          leds,
    output logic [LED_COLS-1:0] lcol
);

    localparam int col_w = $clog2(LED_COLS);
    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;

    data_t            fb_q;
    logic [div_w-1:0] div_cnt;
    logic [col_w-1:0] col_idx;
    logic             col_step;

    // ----------------------------------------
    // Bus side
    // ----------------------------------------

    // Any strobe loads the whole word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fb_q  <= '0;
            ready <= 1'b0;
        end else begin
            ready <= sel;
            if (sel && |wstrb) begin
                fb_q <= wdata;
            end
        end
    end

    assign rdata = fb_q;

    // ----------------------------------------
    // Column scan
    // ----------------------------------------

    // Terminal count of the divider
    assign col_step = div_cnt == div_w'(scan_div - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            col_idx <= '0;
        end else if (col_step) begin
            div_cnt <= '0;
            col_idx <= (col_idx == col_w'(LED_COLS - 1)) ? '0 : col_idx + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Active column pulled low
    assign lcol = ~(LED_COLS'(1) << col_idx);

    // Column 0 shows the top byte, LEDs light on a low level
    always_comb begin
        leds = ~fb_q[8*(LED_COLS - 1 - int'(col_idx)) +: 8];
    end

endmodule

// File: design/scratch_ram.sv
`timescale 1ns/1ns

module scratch_ram
    import iomem_soc_pkg::*;
#(
    parameter int ram_words = 256
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sel,
    input  strb_t wstrb,
    input  addr_t addr,
    input  data_t wdata,
    output logic  ready,
    output data_t rdata
);

    localparam int idx_w = $clog2(ram_words);

    data_t            mem [ram_words];
    logic [idx_w-1:0] word_idx;

    // Word index sits above the byte offset
    assign word_idx = addr[idx_w+1:2];

    // Byte-wise write, one lane per strobe
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (sel && wstrb[i]) begin
                mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Registered read word, presented with ready
    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= sel;
        end
    end

endmodule

// File: dv/tb_iomem_soc.sv
`timescale 1ns/1ns

module tb_iomem_soc
    import iomem_soc_pkg::*;
();

    // Match the DUT defaults
    localparam int ram_words      = 256;
    localparam int gpio_count     = 8;
    localparam int scan_div       = 16;
    localparam int timeout_cycles = 20;
    localparam int ram_tests      = 12;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  iomem_valid;
    strb_t                 iomem_wstrb;
    addr_t                 iomem_addr;
    data_t                 iomem_wdata;
    logic                  iomem_ready;
    data_t                 iomem_rdata;
    logic [gpio_count-1:0] gpio_in;
    logic [gpio_count-1:0] gpio_out;
    logic [gpio_count-1:0] gpio_oe;
    logic [7:0]            leds;
    logic [LED_COLS-1:0]   lcol;

    // Shadow state of the mapped registers
    data_t                 ram_shadow [int];
    logic [gpio_count-1:0] dir_shadow;
    logic [gpio_count-1:0] out_shadow;
    logic [gpio_count-1:0] pin_shadow;
    data_t                 fb_shadow;

    integer seed = 32'ha62;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     test_errors;
    string  test_name;
    logic   expect_read;
    data_t  expect_data;
    addr_t  expect_addr;
    addr_t  ram_addrs [ram_tests];

    iomem_soc iomem_soc_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .gpio_oe     (gpio_oe),
        .leds        (leds),
        .lcol        (lcol)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic data_t ref_read(addr_t addr);
        data_t word;
        int    idx;
        word = '0;
        if ((addr - RAM_BASE) < addr_t'(4 * ram_words)) begin
            idx = int'((addr - RAM_BASE) >> 2);
            word = ram_shadow.exists(idx) ? ram_shadow[idx] : '0;
        end else if (addr == GPIO_DIR_ADDR) begin
            word[gpio_count-1:0] = dir_shadow;
        end else if (addr == GPIO_INPUT_ADDR) begin
            word[gpio_count-1:0] = pin_shadow;
        end else if (addr == GPIO_OUTPUT_ADDR) begin
            word[gpio_count-1:0] = out_shadow;
        end else if (addr == LED_FB_ADDR) begin
            word = fb_shadow;
        end
        return word;
    endfunction

    // Byte merge for RAM, whole register for the peripherals
    function automatic void shadow_write(addr_t addr, strb_t strb, data_t data);
        data_t word;
        int    idx;
        if ((addr - RAM_BASE) < addr_t'(4 * ram_words)) begin
            idx = int'((addr - RAM_BASE) >> 2);
            word = ram_shadow.exists(idx) ? ram_shadow[idx] : '0;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            ram_shadow[idx] = word;
        end else if (|strb) begin
            if (addr == GPIO_DIR_ADDR) begin
                dir_shadow = data[gpio_count-1:0];
            end else if (addr == GPIO_OUTPUT_ADDR) begin
                out_shadow = data[gpio_count-1:0];
            end else if (addr == LED_FB_ADDR) begin
                fb_shadow = data;
            end
        end
    endfunction

    task automatic compare_word(input data_t got, input data_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Read data compare on the ready pulse
    always @(negedge clk) begin
        if (iomem_ready && expect_read) begin
            compare_word(iomem_rdata, expect_data, $sformatf("read of %h", expect_addr));
            expect_read = 1'b0;
        end
    end

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------

    task automatic bus_access(input addr_t addr, input strb_t strb, input data_t data,
                              output bit ok, output int edges);
        @(posedge clk);
        #1;
        iomem_valid = 1'b1;
        iomem_addr  = addr;
        iomem_wstrb = strb;
        iomem_wdata = data;
        edges = 0;
        // Ready before the first edge counts as zero latency
        @(negedge clk);
        ok = iomem_ready;
        while (!ok && edges < timeout_cycles) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            ok = iomem_ready;
        end
        @(posedge clk);
        #1;
        iomem_valid = 1'b0;
        iomem_wstrb = '0;
    endtask

    task automatic check_reply(input bit ok, input int edges, input addr_t addr);
        if (!ok) begin
            $display("Access to %h timed out, no ready within %0d cycles", addr, edges);
            errors++;
        end else begin
            compare_word(data_t'(edges), 32'd1, $sformatf("ready latency at %h", addr));
        end
    endtask

    task automatic bus_write(input addr_t addr, input strb_t strb, input data_t data);
        bit ok;
        int edges;
        bus_access(addr, strb, data, ok, edges);
        check_reply(ok, edges, addr);
        shadow_write(addr, strb, data);
    endtask

    task automatic bus_read(input addr_t addr);
        bit ok;
        int edges;
        expect_addr = addr;
        expect_data = ref_read(addr);
        expect_read = 1'b1;
        bus_access(addr, '0, '0, ok, edges);
        expect_read = 1'b0;
        check_reply(ok, edges, addr);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        bit             ok;
        int             edges;
        int             col;
        strb_t          strb;
        logic [7:0]     exp_leds;
        logic [LED_COLS-1:0] visited;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        expect_read = 1'b0;
        rst_n = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = '0;
        iomem_addr = '0;
        iomem_wdata = '0;
        gpio_in = '0;
        dir_shadow = '0;
        out_shadow = '0;
        pin_shadow = '0;
        fb_shadow = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        compare_word(data_t'(iomem_ready), 32'h0, "iomem_ready after reset");
        compare_word(data_t'(gpio_oe), 32'h0, "gpio_oe after reset");
        compare_word(data_t'(leds), 32'hff, "leds after reset");
        compare_word(data_t'(lcol), 32'he, "lcol after reset");
        end_test();

        start_test("ram");
        for (int i = 0; i < ram_tests; i++) begin
            ram_addrs[i] = RAM_BASE + addr_t'(($unsigned($random(seed)) % ram_words) * 4);
            bus_write(ram_addrs[i], 4'hf, data_t'($random(seed)));
            strb = strb_t'($random(seed));
            // Zero strobes would turn the access into a read
            if (strb == '0) begin
                strb = 4'h1;
            end
            bus_write(ram_addrs[i], strb, data_t'($random(seed)));
        end
        for (int i = 0; i < ram_tests; i++) begin
            bus_read(ram_addrs[i]);
        end
        end_test();

        start_test("gpio");
        bus_write(GPIO_DIR_ADDR, 4'hf, data_t'($random(seed)));
        bus_write(GPIO_OUTPUT_ADDR, 4'hf, data_t'($random(seed)));
        @(negedge clk);
        compare_word(data_t'(gpio_oe), data_t'(dir_shadow), "gpio_oe");
        compare_word(data_t'(gpio_out), data_t'(out_shadow), "gpio_out");
        bus_read(GPIO_DIR_ADDR);
        bus_read(GPIO_OUTPUT_ADDR);
        @(posedge clk);
        #1;
        pin_shadow = gpio_count'($random(seed));
        gpio_in = pin_shadow;
        repeat (3) @(posedge clk);
        bus_read(GPIO_INPUT_ADDR);
        end_test();

        start_test("led");
        bus_write(LED_FB_ADDR, 4'hf, data_t'($random(seed)));
        bus_read(LED_FB_ADDR);
        visited = '0;
        for (int c = 0; c < LED_COLS * scan_div; c++) begin
            @(negedge clk);
            col = -1;
            for (int k = 0; k < LED_COLS; k++) begin
                if (lcol == ~(LED_COLS'(1) << k)) begin
                    col = k;
                end
            end
            checks++;
            assert (col >= 0) else begin
                $display("Column select %b does not have exactly one active column", lcol);
                errors++;
            end
            if (col >= 0) begin
                visited = visited | (LED_COLS'(1) << col);
                exp_leds = ~fb_shadow[8*(LED_COLS-1-col) +: 8];
                compare_word(data_t'(leds), data_t'(exp_leds),
                             $sformatf("leds in column %0d", col));
            end
        end
        compare_word(data_t'(visited), data_t'({LED_COLS{1'b1}}), "columns visited");
        end_test();

        start_test("unmapped");
        bus_access(32'h2000_0000, '0, '0, ok, edges);
        checks++;
        assert (!ok) else begin
            $display("FAILED at %0t ns: unmapped address got ready", $time);
            errors++;
        end
        bus_read(ram_addrs[0]);
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: iomem_soc.f
design/iomem_soc_pkg.sv
design/iomem_decode.sv
design/scratch_ram.sv
design/gpio_ctrl.sv
design/led_matrix_fb.sv
design/iomem_soc.sv
dv/tb_iomem_soc.sv
